// ==== project.f ====
+incdir+testbench
src/quant_pkg.sv
src/quant_axil_slave.sv
src/quant_csr_decode.sv
src/quant_execute.sv
src/quant_result.sv
src/quant_top.sv
testbench/tb_quant_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, exit status follows the log verdict
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_quant_top -f project.f \
    && ./obj_dir/Vtb_quant_top | tee sim.log
grep -qsx "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_quant_model.svh ====
// Included inside tb_quant_top; the scaled product wraps at 32 bits like the reference integer math
`ifndef tb_quant_model_svh
`define tb_quant_model_svh

// ----------------------------------------------------------------------
// Random source
// ----------------------------------------------------------------------
logic [31:0] lfsr_state = 32'h8ed3;

// Galois form, one step for every bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'ha300_0000 : lfsr_state >> 1;
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// ----------------------------------------------------------------------
// Reference quantizer
// ----------------------------------------------------------------------
// Scan position k holds raster coefficient zigzag_scan[k]
localparam int zigzag_scan [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

// Block under test, parameter index 0 is the DC set
logic [15:0] coeff_m   [16];
logic [15:0] q_m       [2];
logic [15:0] iq_m      [2];
logic [15:0] sharpen_m [2];
logic [31:0] bias_m    [2];
logic [31:0] zthr_m    [2];
int          check_count;
int          err_count;

task automatic model_coeff(input int idx, output logic [15:0] lvl, output logic [15:0] rec);
    int          s;
    logic [31:0] mag;
    logic [31:0] acc;
    logic [31:0] lv;
    s   = (idx == 0) ? 0 : 1;
    mag = {16'd0, coeff_m[idx][15] ? (~coeff_m[idx] + 16'd1) : coeff_m[idx]};
    mag = mag + {16'd0, sharpen_m[s]};
    acc = mag * {16'd0, iq_m[s]} + bias_m[s];
    lv  = acc >> 17;
    if (lv > 32'd2047) begin
        lv = 32'd2047;
    end
    // Magnitude plus sharpen must exceed the threshold
    if (mag <= zthr_m[s]) begin
        lv = 32'd0;
    end
    lvl = coeff_m[idx][15] ? (16'd0 - lv[15:0]) : lv[15:0];
    rec = lvl * q_m[s];
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

`endif

// ==== testbench/tb_quant_top.sv ====
// Testbench for quant_top; needs timing support in the simulator, one block in flight at a time
`timescale 1ns/1ps

module tb_quant_top import quant_pkg::*; ();

    localparam int clk_period   = 100;
    localparam int block_budget = 500;
    localparam int num_random   = 40;
    localparam int num_stall    = 4;
    // Random, stall, limit and status blocks, two more for register traffic
    localparam int total_blocks = num_random + num_stall + 6;
    localparam int watchdog_ns  = total_blocks * block_budget * clk_period;
    localparam int max_polls    = 64;

    logic        clk;
    logic        rst_n;
    logic        awvalid_i;
    logic        awready_o;
    logic [31:0] awaddr_i;
    logic        wvalid_i;
    logic        wready_o;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic        bvalid_o;
    logic        bready_i;
    logic [1:0]  bresp_o;
    logic        arvalid_i;
    logic        arready_o;
    logic [31:0] araddr_i;
    logic        rvalid_o;
    logic        rready_i;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        stall_mode;
    int          test_count;
    int          test_base;
    logic [15:0] level_rd [16];
    logic [15:0] recon_rd [16];
    logic        nz_rd;

    `include "tb_quant_model.svh"

    quant_top quant_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // AXI4-Lite driver, every task starts and ends on a falling edge
    // ------------------------------------------------------------------
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int stall;
        awvalid_i = 1'b1;
        awaddr_i  = addr;
        wvalid_i  = 1'b1;
        wdata_i   = data;
        wstrb_i   = 4'hf;
        #1;
        while (!awready_o) begin
            @(negedge clk);
            #1;
        end
        // Address and data channels are accepted together
        check_value("wready_o", 32'(wready_o), 32'd1);
        @(negedge clk);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        while (!bvalid_o) begin
            @(negedge clk);
        end
        resp  = bresp_o;
        stall = stall_mode ? int'(rand_bits(3)) : 0;
        repeat (stall) begin
            @(negedge clk);
            check_value("bvalid_o", 32'(bvalid_o), 32'd1);
            check_value("bresp_o", 32'(bresp_o), 32'(resp));
        end
        bready_i = 1'b1;
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int stall;
        arvalid_i = 1'b1;
        araddr_i  = addr;
        #1;
        while (!arready_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid_i = 1'b0;
        while (!rvalid_o) begin
            @(negedge clk);
        end
        data  = rdata_o;
        resp  = rresp_o;
        stall = stall_mode ? int'(rand_bits(3)) : 0;
        repeat (stall) begin
            @(negedge clk);
            check_value("rvalid_o", 32'(rvalid_o), 32'd1);
            check_value("rdata_o", rdata_o, data);
            check_value("rresp_o", 32'(rresp_o), 32'(resp));
        end
        rready_i = 1'b1;
        @(negedge clk);
        rready_i = 1'b0;
    endtask

    task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        bus_write(addr, data, resp);
        check_value("bresp_o", 32'(resp), 32'(RESP_OKAY));
    endtask

    task automatic read_ok(input logic [31:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        bus_read(addr, data, resp);
        check_value("rresp_o", 32'(resp), 32'(RESP_OKAY));
    endtask

    // ------------------------------------------------------------------
    // Block helpers
    // ------------------------------------------------------------------
    task automatic randomize_block();
        logic [9:0] small_val;
        for (int i = 0; i < 16; i++) begin
            small_val  = 10'(rand_bits(10));
            coeff_m[i] = rand_bits(1) ? 16'(rand_bits(16)) : {{6{small_val[9]}}, small_val};
        end
        for (int s = 0; s < 2; s++) begin
            q_m[s]       = 16'(rand_bits(8));
            iq_m[s]      = 16'(rand_bits(16));
            sharpen_m[s] = 16'(rand_bits(6));
            bias_m[s]    = rand_bits(17);
            zthr_m[s]    = rand_bits(10);
        end
    endtask

    task automatic load_block();
        for (int w = 0; w < 8; w++) begin
            write_ok(32'(ADDR_COEFF_BASE) + 32'(4 * w), {coeff_m[2*w+1], coeff_m[2*w]});
        end
        write_ok(32'(ADDR_Q), {q_m[1], q_m[0]});
        write_ok(32'(ADDR_IQ), {iq_m[1], iq_m[0]});
        write_ok(32'(ADDR_SHARPEN), {sharpen_m[1], sharpen_m[0]});
        write_ok(32'(ADDR_BIAS_DC), bias_m[0]);
        write_ok(32'(ADDR_BIAS_AC), bias_m[1]);
        write_ok(32'(ADDR_ZTHR_DC), zthr_m[0]);
        write_ok(32'(ADDR_ZTHR_AC), zthr_m[1]);
    endtask

    task automatic wait_done();
        logic [31:0] data;
        int          polls;
        polls = 0;
        data  = '0;
        while (!data[0] && polls < max_polls) begin
            read_ok(32'(ADDR_STATUS), data);
            polls++;
        end
        nz_rd = data[1];
        if (!data[0]) begin
            $display("the block did not finish within %0d status polls", max_polls);
            err_count++;
        end
    endtask

    task automatic check_results();
        logic [15:0] lvl [16];
        logic [15:0] rec [16];
        logic [31:0] data;
        logic        nz;
        nz = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_coeff(i, lvl[i], rec[i]);
            nz = nz | (lvl[i] != 16'd0);
        end
        check_value("rdata_o nz", 32'(nz_rd), 32'(nz));
        for (int w = 0; w < 8; w++) begin
            read_ok(32'(ADDR_LEVEL_BASE) + 32'(4 * w), data);
            {level_rd[2*w+1], level_rd[2*w]} = data;
            check_value($sformatf("rdata_o level word %0d", w), data,
                        {lvl[zigzag_scan[2*w+1]], lvl[zigzag_scan[2*w]]});
            read_ok(32'(ADDR_RECON_BASE) + 32'(4 * w), data);
            {recon_rd[2*w+1], recon_rd[2*w]} = data;
            check_value($sformatf("rdata_o recon word %0d", w), data,
                        {rec[2*w+1], rec[2*w]});
        end
    endtask

    task automatic run_block();
        load_block();
        write_ok(32'(ADDR_CTRL), 32'd1);
        wait_done();
        check_results();
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - test_base);
        test_base = err_count;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_registers();
        logic [31:0] addr [15];
        logic [31:0] val  [15];
        logic [31:0] data;
        // Coefficient words, then Q through ZTHR_AC which are contiguous
        for (int i = 0; i < 15; i++) begin
            addr[i] = (i < 8) ? 32'(ADDR_COEFF_BASE) + 32'(4 * i) : 32'(ADDR_Q) + 32'(4 * (i - 8));
            val[i]  = rand_bits(32);
            write_ok(addr[i], val[i]);
        end
        for (int i = 0; i < 15; i++) begin
            read_ok(addr[i], data);
            check_value($sformatf("rdata_o at 0x%02h", addr[i]), data, val[i]);
        end
    endtask

    task automatic test_limits();
        logic [15:0] mag;
        randomize_block();
        for (int i = 0; i < 16; i++) begin
            mag        = {2'b01, 14'(rand_bits(14))};
            coeff_m[i] = rand_bits(1) ? 16'd0 - mag : mag;
        end
        for (int s = 0; s < 2; s++) begin
            iq_m[s]      = 16'hffff;
            sharpen_m[s] = 16'd0;
            bias_m[s]    = 32'd0;
            zthr_m[s]    = 32'd0;
        end
        run_block();
        for (int k = 0; k < 16; k++) begin
            check_value($sformatf("rdata_o clamped level %0d", k), 32'(level_rd[k]),
                        coeff_m[zigzag_scan[k]][15] ? 32'h0000_f801 : 32'h0000_07ff);
        end
        // Threshold above every magnitude plus sharpen
        for (int s = 0; s < 2; s++) begin
            sharpen_m[s] = 16'(rand_bits(8));
            zthr_m[s]    = 32'h0002_0000;
        end
        run_block();
        for (int k = 0; k < 16; k++) begin
            check_value($sformatf("rdata_o zero level %0d", k), 32'(level_rd[k]), 32'd0);
            check_value($sformatf("rdata_o zero recon %0d", k), 32'(recon_rd[k]), 32'd0);
        end
        check_value("rdata_o nz", 32'(nz_rd), 32'd0);
    endtask

    task automatic test_status();
        logic [31:0] data;
        logic [15:0] fresh [16];
        randomize_block();
        load_block();
        write_ok(32'(ADDR_CTRL), 32'd1);
        read_ok(32'(ADDR_STATUS), data);
        check_value("rdata_o done", 32'(data[0]), 32'd0);
        wait_done();
        read_ok(32'(ADDR_STATUS), data);
        check_value("rdata_o done", 32'(data[0]), 32'd1);
        check_results();
        // New coefficients land while the old block is in flight
        randomize_block();
        for (int i = 0; i < 16; i++) begin
            fresh[i] = 16'(rand_bits(16));
        end
        load_block();
        write_ok(32'(ADDR_CTRL), 32'd1);
        for (int w = 0; w < 8; w++) begin
            write_ok(32'(ADDR_COEFF_BASE) + 32'(4 * w), {fresh[2*w+1], fresh[2*w]});
        end
        wait_done();
        check_results();
    endtask

    task automatic test_stall_errors();
        logic [31:0] bad_wr [5];
        logic [31:0] bad_rd [4];
        logic [31:0] data;
        logic [1:0]  resp;
        bad_wr = '{32'h08, 32'h04, 32'h80, 32'h4c, 32'h100};
        bad_rd = '{32'h0c, 32'h4c, 32'ha0, 32'h100};
        stall_mode = 1'b1;
        repeat (num_stall) begin
            randomize_block();
            run_block();
        end
        for (int i = 0; i < 5; i++) begin
            bus_write(bad_wr[i], rand_bits(32), resp);
            check_value($sformatf("bresp_o at 0x%03h", bad_wr[i]), 32'(resp), 32'(RESP_SLVERR));
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(bad_rd[i], data, resp);
            check_value($sformatf("rresp_o at 0x%03h", bad_rd[i]), 32'(resp), 32'(RESP_SLVERR));
        end
        stall_mode = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        awvalid_i  = 1'b0;
        awaddr_i   = '0;
        wvalid_i   = 1'b0;
        wdata_i    = '0;
        wstrb_i    = '0;
        bready_i   = 1'b0;
        arvalid_i  = 1'b0;
        araddr_i   = '0;
        rready_i   = 1'b0;
        stall_mode = 1'b0;
        test_count = 0;
        test_base  = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_registers();
        end_test("register access");
        repeat (num_random) begin
            randomize_block();
            run_block();
        end
        end_test("random blocks");
        test_limits();
        end_test("limits and zero threshold");
        test_status();
        end_test("status and pipeline");
        test_stall_errors();
        end_test("back-pressure and errors");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/quant_top.sv ====
// Quantizer with AXI4-Lite access; one block in flight is expected per start.
`timescale 1ns/1ps

module quant_top import quant_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic [1:0]  bresp_o,
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [31:0] araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o
);

    reg_req_t     req;
    reg_rsp_t     rsp;
    logic [2:0]   res_index;
    csr_op_e      res_sel;
    logic [31:0]  res_data;
    logic         start;
    coeff_block_t coeff;
    quant_param_t dc_param;
    quant_param_t ac_param;
    logic         exe_valid;
    coeff_block_t level;
    coeff_block_t recon;

    quant_axil_slave axil_slave_i (
        .clk, .rst_n,
        .awvalid_i, .awready_o, .awaddr_i,
        .wvalid_i, .wready_o, .wdata_i, .wstrb_i,
        .bvalid_o, .bready_i, .bresp_o,
        .arvalid_i, .arready_o, .araddr_i,
        .rvalid_o, .rready_i, .rdata_o, .rresp_o,
        .req_o (req),
        .rsp_i (rsp)
    );

    quant_csr_decode csr_decode_i (
        .clk, .rst_n,
        .req_i       (req),
        .rsp_o       (rsp),
        .res_index_o (res_index),
        .res_sel_o   (res_sel),
        .res_data_i  (res_data),
        .start_o     (start),
        .coeff_o     (coeff),
        .dc_param_o  (dc_param),
        .ac_param_o  (ac_param)
    );

    quant_execute execute_i (
        .clk, .rst_n,
        .start_i    (start),
        .coeff_i    (coeff),
        .dc_param_i (dc_param),
        .ac_param_i (ac_param),
        .valid_o    (exe_valid),
        .level_o    (level),
        .recon_o    (recon)
    );

    quant_result result_i (
        .clk, .rst_n,
        .start_i    (start),
        .valid_i    (exe_valid),
        .level_i    (level),
        .recon_i    (recon),
        .rd_sel_i   (res_sel),
        .rd_index_i (res_index),
        .rd_data_o  (res_data)
    );

endmodule

// ==== src/quant_result.sv ====
// Result store for the last finished block; only the newest block is kept.
`timescale 1ns/1ps

module quant_result import quant_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_i,
    input  logic         valid_i,
    input  coeff_block_t level_i,
    input  coeff_block_t recon_i,
    input  csr_op_e      rd_sel_i,
    input  logic [2:0]   rd_index_i,
    output logic [31:0]  rd_data_o
);

    coeff_block_t level_zz;
    coeff_block_t level_q;
    coeff_block_t recon_q;
    logic         nz_q;
    logic         done_q;

    always_comb begin
        for (int k = 0; k < NUM_COEFF; k++) begin
            level_zz[k] = level_i[ZIGZAG[k]];
        end
    end

    // ------------------------------------------------------------------
    // Capture and status
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= '0;
            recon_q <= '0;
            nz_q    <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            // A new start wins over a block finishing in the same cycle
            if (start_i) begin
                done_q <= 1'b0;
            end else if (valid_i) begin
                done_q <= 1'b1;
            end
            if (valid_i) begin
                level_q <= level_zz;
                recon_q <= recon_i;
                nz_q    <= |level_i;
            end
        end
    end

    always_comb begin
        case (rd_sel_i)
            // done drops already in the start cycle
            op_rd_status: rd_data_o = {30'd0, nz_q, done_q && !start_i};
            op_rd_level:  rd_data_o = level_q[{rd_index_i, 1'b0} +: 2];
            op_rd_recon:  rd_data_o = recon_q[{rd_index_i, 1'b0} +: 2];
            default:      rd_data_o = '0;
        endcase
    end

endmodule

// ==== src/quant_execute.sv ====
// Two-stage quantizer, one block per start; products and sums wrap at 32 bits.
`timescale 1ns/1ps

module quant_execute import quant_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_i,
    input  coeff_block_t coeff_i,
    input  quant_param_t dc_param_i,
    input  quant_param_t ac_param_i,
    output logic         valid_o,
    output coeff_block_t level_o,
    output coeff_block_t recon_o
);

    logic s1_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s1_valid <= start_i;
            valid_o  <= s1_valid;
        end
    end

    for (genvar i = 0; i < NUM_COEFF; i++) begin : g_lane
        quant_param_t        prm;
        logic                sign;
        logic [15:0]         mag;
        logic [31:0]         mag_sharp;
        logic [31:0]         scaled;
        logic [31-QFIX:0]    s1_level;
        logic                s1_sign;
        logic                s1_keep;
        logic [15:0]         s1_q;
        logic [15:0]         clamped;
        logic [15:0]         signed_level;
        logic [15:0]         recon_w;

        // DC position has its own parameter set
        assign prm       = (i == 0) ? dc_param_i : ac_param_i;
        assign sign      = coeff_i[i][15];
        assign mag       = sign ? 16'(-coeff_i[i]) : coeff_i[i];
        assign mag_sharp = 32'(mag) + 32'(prm.sharpen);
        assign scaled    = mag_sharp * 32'(prm.iq) + prm.bias;

        // ------------------------------------------------------------------
        // Stage one: scaled level and zero-threshold decision
        // ------------------------------------------------------------------
        always_ff @(posedge clk) begin
            s1_level <= scaled[31:QFIX];
            s1_sign  <= sign;
            s1_keep  <= mag_sharp > prm.zthresh;
            s1_q     <= prm.q;
        end

        assign clamped      = (s1_level > MAX_LEVEL) ? 16'(MAX_LEVEL) : 16'(s1_level);
        assign signed_level = s1_sign ? 16'd0 - clamped : clamped;
        // Only the low 16 bits are kept, sign comes out right
        assign recon_w      = signed_level * s1_q;

        // Stage two: signed level and reconstruction
        always_ff @(posedge clk) begin
            level_o[i] <= s1_keep ? signed_level : 16'd0;
            recon_o[i] <= s1_keep ? recon_w : 16'd0;
        end

        a_level_range: assert property (@(posedge clk) disable iff (!rst_n)
            valid_o |-> ($signed(level_o[i]) <= MAX_LEVEL) &&
                        ($signed(level_o[i]) >= -MAX_LEVEL));
    end

endmodule

// ==== src/quant_csr_decode.sv ====
// Register file for the quantizer; parameters are shared by AC positions 1..15, CTRL reads 0.
`timescale 1ns/1ps

module quant_csr_decode import quant_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  reg_req_t     req_i,
    output reg_rsp_t     rsp_o,
    // Read link to the result store
    output logic [2:0]   res_index_o,
    output csr_op_e      res_sel_o,
    input  logic [31:0]  res_data_i,
    // Block launch
    output logic         start_o,
    output coeff_block_t coeff_o,
    output quant_param_t dc_param_o,
    output quant_param_t ac_param_o
);

    csr_op_e      op;
    logic [7:0]   offset;
    logic [2:0]   coeff_word;
    logic [31:0]  param_rdata;
    logic [31:0]  wr_word;
    coeff_block_t coeff_q;
    quant_param_t dc_q;
    quant_param_t ac_q;

    function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
        end
        return res;
    endfunction

    assign offset     = {req_i.addr[5:0], 2'b00};
    // Coefficient words start at word address 4
    assign coeff_word = req_i.addr[2:0] - 3'd4;

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    always_comb begin
        op = op_none;
        if (req_i.valid) begin
            op = op_bad;
            if (req_i.addr[29:6] == '0) begin
                case (offset) inside
                    ADDR_CTRL:   op = req_i.write ? op_start : op_rd_param;
                    ADDR_STATUS: op = req_i.write ? op_bad : op_rd_status;
                    [ADDR_COEFF_BASE:ADDR_COEFF_BASE + 8'h1C]:
                        op = req_i.write ? op_wr_coeff : op_rd_param;
                    [ADDR_Q:ADDR_ZTHR_AC]:
                        op = req_i.write ? op_wr_param : op_rd_param;
                    [ADDR_LEVEL_BASE:ADDR_LEVEL_BASE + 8'h1C]:
                        op = req_i.write ? op_bad : op_rd_level;
                    [ADDR_RECON_BASE:ADDR_RECON_BASE + 8'h1C]:
                        op = req_i.write ? op_bad : op_rd_recon;
                    default:     op = op_bad;
                endcase
            end
        end
    end

    // Current contents of the addressed word, also the base for strobed writes
    always_comb begin
        param_rdata = '0;
        case (offset) inside
            [ADDR_COEFF_BASE:ADDR_COEFF_BASE + 8'h1C]:
                param_rdata = coeff_q[{coeff_word, 1'b0} +: 2];
            ADDR_Q:       param_rdata = {ac_q.q, dc_q.q};
            ADDR_IQ:      param_rdata = {ac_q.iq, dc_q.iq};
            ADDR_SHARPEN: param_rdata = {ac_q.sharpen, dc_q.sharpen};
            ADDR_BIAS_DC: param_rdata = dc_q.bias;
            ADDR_BIAS_AC: param_rdata = ac_q.bias;
            ADDR_ZTHR_DC: param_rdata = dc_q.zthresh;
            ADDR_ZTHR_AC: param_rdata = ac_q.zthresh;
            default:      param_rdata = '0;
        endcase
    end

    assign wr_word = merge_strb(param_rdata, req_i.wdata, req_i.strb);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_o <= 1'b0;
            coeff_q <= '0;
            dc_q    <= '0;
            ac_q    <= '0;
        end else begin
            start_o <= (op == op_start) && req_i.strb[0] && req_i.wdata[0];
            if (op == op_wr_coeff) begin
                coeff_q[{coeff_word, 1'b0} +: 2] <= wr_word;
            end
            if (op == op_wr_param) begin
                case (offset)
                    ADDR_Q:       {ac_q.q, dc_q.q} <= wr_word;
                    ADDR_IQ:      {ac_q.iq, dc_q.iq} <= wr_word;
                    ADDR_SHARPEN: {ac_q.sharpen, dc_q.sharpen} <= wr_word;
                    ADDR_BIAS_DC: dc_q.bias <= wr_word;
                    ADDR_BIAS_AC: ac_q.bias <= wr_word;
                    ADDR_ZTHR_DC: dc_q.zthresh <= wr_word;
                    ADDR_ZTHR_AC: ac_q.zthresh <= wr_word;
                    default:      dc_q <= dc_q;
                endcase
            end
        end
    end

    assign res_index_o = req_i.addr[2:0];
    assign res_sel_o   = op;
    assign rsp_o.rdata = (op inside {op_rd_status, op_rd_level, op_rd_recon}) ?
                         res_data_i : param_rdata;
    assign rsp_o.err   = (op == op_bad);
    assign coeff_o     = coeff_q;
    assign dc_param_o  = dc_q;
    assign ac_param_o  = ac_q;

    // The bus slave cannot accept two writes on adjacent cycles
    a_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        start_o |=> !start_o);

endmodule

// ==== src/quant_axil_slave.sv ====
// AXI4-Lite slave, one outstanding read and one outstanding write; address bits 1:0 are ignored.
`timescale 1ns/1ps

module quant_axil_slave import quant_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Write address and data
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    // Write response
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic [1:0]  bresp_o,
    // Read address and data
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [31:0] araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    // Register side
    output reg_req_t    req_o,
    input  reg_rsp_t    rsp_i
);

    logic wr_fire;
    logic rd_fire;

    // Address and data are taken together, and a write beats a read
    assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
    assign rd_fire   = arvalid_i && !rvalid_o && !wr_fire;
    assign awready_o = wr_fire;
    assign wready_o  = wr_fire;
    assign arready_o = rd_fire;

    always_comb begin
        req_o = '0;
        if (wr_fire) begin
            req_o.valid = 1'b1;
            req_o.write = 1'b1;
            req_o.addr  = awaddr_i[31:2];
            req_o.wdata = wdata_i;
            req_o.strb  = wstrb_i;
        end else if (rd_fire) begin
            req_o.valid = 1'b1;
            req_o.addr  = araddr_i[31:2];
        end
    end

    // ------------------------------------------------------------------
    // Response channels
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_o <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_fire) begin
            rdata_o <= rsp_i.rdata;
            rresp_o <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Responses wait for the master, payload frozen meanwhile
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

// ==== src/quant_pkg.sv ====
// Register map and types for the 4x4 quantizer. Coefficients are 16-bit two's complement only.
package quant_pkg;

    // ------------------------------------------------------------------
    // Block geometry and quantizer limits
    // ------------------------------------------------------------------
    localparam int NUM_COEFF = 16;
    localparam int QFIX      = 17;
    localparam int MAX_LEVEL = 2047;

    // Zigzag scan, output position k takes raster index ZIGZAG[k]
    localparam int ZIGZAG [NUM_COEFF] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    // AXI4-Lite response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ------------------------------------------------------------------
    // Register map, byte offsets
    // ------------------------------------------------------------------
    localparam logic [7:0] ADDR_CTRL       = 8'h00;
    localparam logic [7:0] ADDR_STATUS     = 8'h04;
    localparam logic [7:0] ADDR_COEFF_BASE = 8'h10;
    localparam logic [7:0] ADDR_Q          = 8'h30;
    localparam logic [7:0] ADDR_IQ         = 8'h34;
    localparam logic [7:0] ADDR_SHARPEN    = 8'h38;
    localparam logic [7:0] ADDR_BIAS_DC    = 8'h3C;
    localparam logic [7:0] ADDR_BIAS_AC    = 8'h40;
    localparam logic [7:0] ADDR_ZTHR_DC    = 8'h44;
    localparam logic [7:0] ADDR_ZTHR_AC    = 8'h48;
    localparam logic [7:0] ADDR_LEVEL_BASE = 8'h80;
    localparam logic [7:0] ADDR_RECON_BASE = 8'hC0;

    typedef enum logic [3:0] {
        op_none,
        op_start,
        op_wr_coeff,
        op_wr_param,
        op_rd_param,
        op_rd_status,
        op_rd_level,
        op_rd_recon,
        op_bad
    } csr_op_e;

    // Single register access, addr is the word address
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [29:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } reg_rsp_t;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [15:0] sharpen;
        logic [31:0] bias;
        logic [31:0] zthresh;
    } quant_param_t;

    // Sixteen two's complement values, index 0 in the low bits
    typedef logic [NUM_COEFF-1:0][15:0] coeff_block_t;

endpackage
